//--- sys_pkg.sv
////////////////////
// System package
// Shared types, host command codes and memory constants
// for the command port, memory readers and audio mixer
////////////////////
package sys_pkg;

	// Host and memory data types
	typedef logic [15:0] word_t;
	typedef logic [28:0] mem_addr_t;
	typedef logic [63:0] mem_data_t;

	// Audio and video payloads
	typedef logic signed [15:0] sample_t;
	typedef logic [23:0] pal_entry_t;

	// Crossfeed modes
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_FULL = 2'd3
	} mix_mode_t;

	// Framebuffer setup, base is a byte address
	typedef struct packed {
		logic        enable;
		logic [5:0]  format;
		logic [31:0] base;
	} fb_cfg_t;

	////////////////////
	// Host command codes
	////////////////////
	localparam logic [7:0] CMD_LED = 8'h25;
	localparam logic [7:0] CMD_VOL = 8'h26;
	localparam logic [7:0] CMD_FB  = 8'h2F;

	// Low format bits for 8-bit palette mode
	localparam logic [2:0] FB_FMT_PAL = 3'b011;

	// PCM ring buffer, in 64-bit words
	localparam mem_addr_t PCM_BASE = 29'h0010_0000;

endpackage

//--- mem_rd_if.sv
////////////////////
// Memory read channel
// Request with address and wait, data returned with rvalid
////////////////////
`timescale 1ns/1ps

interface mem_rd_if import sys_pkg::*; ();

	logic      rd;
	mem_addr_t addr;
	logic      waitreq;
	mem_data_t rdata;
	logic      rvalid;

	// Reader side
	modport client (
		output rd,
		output addr,
		input  waitreq,
		input  rdata,
		input  rvalid
	);

	// Arbiter side of a client channel
	modport arbiter (
		input  rd,
		input  addr,
		output waitreq,
		output rdata,
		output rvalid
	);

	// Memory side
	modport memory (
		input  rd,
		input  addr,
		output waitreq,
		output rdata,
		output rvalid
	);

endinterface

//--- host_cmd.sv
////////////////////
// Host command decoder
// First word after select is the command, the rest is data
// Holds LED, volume and framebuffer registers
////////////////////
`timescale 1ns/1ps

module host_cmd import sys_pkg::*; (
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_io_uio,
	input  logic       i_io_strobe,
	input  word_t      i_io_din,
	input  logic [7:0] i_led_core,
	output logic [7:0] o_led,
	output logic [4:0] o_vol_att,
	output fb_cfg_t    o_fb_cfg
);

	logic       uio_s;
	logic       strobe_s;
	logic       strobe_d;
	word_t      din_s;
	logic       strobe_rise;
	logic       has_cmd;
	logic [7:0] cmd;
	logic [1:0] cnt;
	logic [7:0] led_overtake;
	logic [7:0] led_state;

	// Sample the host port once, then find the strobe edge
	always_ff @(posedge clk) begin
		if (resetd) begin
			uio_s    <= 1'b0;
			strobe_s <= 1'b0;
			strobe_d <= 1'b0;
		end else begin
			uio_s    <= i_io_uio;
			strobe_s <= i_io_strobe;
			strobe_d <= strobe_s;
		end
	end

	always_ff @(posedge clk) begin
		din_s <= i_io_din;
	end

	assign strobe_rise = strobe_s & ~strobe_d;

	////////////////////
	// Command decode
	////////////////////
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= 8'd0;
			cnt          <= 2'd0;
			led_overtake <= 8'd0;
			led_state    <= 8'd0;
			o_vol_att    <= 5'd0;
			o_fb_cfg     <= '0;
		end else if (!uio_s) begin
			has_cmd <= 1'b0;
			cmd     <= 8'd0;
			cnt     <= 2'd0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_s[7:0];
				cnt     <= 2'd0;
			end else begin
				case (cmd)
					CMD_LED: {led_overtake, led_state} <= din_s;
					CMD_VOL: o_vol_att <= din_s[4:0];
					CMD_FB: begin
						// Setup word, then base low and high halves
						case (cnt)
							2'd0: begin
								o_fb_cfg.enable <= din_s[15];
								o_fb_cfg.format <= din_s[5:0];
							end
							2'd1: o_fb_cfg.base[15:0] <= din_s;
							2'd2: o_fb_cfg.base[31:16] <= din_s;
							default: ;
						endcase
						if (cnt != 2'd3)
							cnt <= cnt + 2'd1;
					end
					default: ;
				endcase
			end
		end
	end

	// Overtaken bits show the host state, the rest come from the core
	always_ff @(posedge clk) begin
		o_led <= (led_overtake & led_state) | (~led_overtake & i_led_core);
	end

endmodule

//--- mem_arbiter.sv
////////////////////
// Memory read arbiter
// Round-robin between PCM (c0) and palette (c1)
// Grant held from request until its rvalid
////////////////////
`timescale 1ns/1ps

module mem_arbiter (
	input logic       clk,
	input logic       resetd,
	mem_rd_if.arbiter c0,
	mem_rd_if.arbiter c1,
	mem_rd_if.client  m
);

	logic gnt0;
	logic gnt1;
	logic last1;
	logic idle;
	logic pick0;
	logic pick1;
	logic own0;
	logic own1;

	assign idle = ~gnt0 & ~gnt1;

	// c0 wins a tie only if c1 was served last
	assign pick0 = idle & c0.rd & (~c1.rd | last1);
	assign pick1 = idle & c1.rd & ~pick0;

	assign own0 = gnt0 | pick0;
	assign own1 = gnt1 | pick1;

	// Request path
	assign m.rd   = (own0 & c0.rd) | (own1 & c1.rd);
	assign m.addr = own1 ? c1.addr : c0.addr;

	// Response path, the loser sees wait
	assign c0.waitreq = ~own0 | m.waitreq;
	assign c1.waitreq = ~own1 | m.waitreq;
	assign c0.rdata   = m.rdata;
	assign c1.rdata   = m.rdata;
	assign c0.rvalid  = gnt0 & m.rvalid;
	assign c1.rvalid  = gnt1 & m.rvalid;

	always_ff @(posedge clk) begin
		if (resetd) begin
			gnt0  <= 1'b0;
			gnt1  <= 1'b0;
			last1 <= 1'b0;
		end else if (m.rvalid) begin
			gnt0 <= 1'b0;
			gnt1 <= 1'b0;
		end else if (pick0) begin
			gnt0  <= 1'b1;
			last1 <= 1'b0;
		end else if (pick1) begin
			gnt1  <= 1'b1;
			last1 <= 1'b1;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (resetd)
		!(own0 && own1));

	a_rvalid_granted: assert property (@(posedge clk) disable iff (resetd)
		m.rvalid |-> (gnt0 || gnt1));

endmodule

//--- pcm_fetch.sv
////////////////////
// PCM sample reader
// One stereo word per sample strobe from the ring buffer
////////////////////
`timescale 1ns/1ps

module pcm_fetch import sys_pkg::*; #(
	parameter int PCM_DEPTH = 16
) (
	input  logic      clk,
	input  logic      resetd,
	input  logic      i_sample_ce,
	mem_rd_if.client  mem,
	output sample_t   o_pcm_l,
	output sample_t   o_pcm_r
);

	localparam int IW = (PCM_DEPTH > 1) ? $clog2(PCM_DEPTH) : 1;

	logic          rd_r;
	logic          pend;
	logic [IW-1:0] idx;

	assign mem.rd   = rd_r;
	assign mem.addr = PCM_BASE + mem_addr_t'(idx);

	always_ff @(posedge clk) begin
		if (resetd) begin
			rd_r    <= 1'b0;
			pend    <= 1'b0;
			idx     <= '0;
			o_pcm_l <= '0;
			o_pcm_r <= '0;
		end else begin
			// A strobe during a pending fetch is dropped
			if (i_sample_ce && !pend) begin
				rd_r <= 1'b1;
				pend <= 1'b1;
			end else if (rd_r && !mem.waitreq) begin
				rd_r <= 1'b0;
			end

			if (mem.rvalid) begin
				pend    <= 1'b0;
				o_pcm_l <= mem.rdata[15:0];
				o_pcm_r <= mem.rdata[31:16];
				// Step after the data so addr stays put while waiting
				if (idx == IW'(PCM_DEPTH - 1))
					idx <= '0;
				else
					idx <= idx + 1'b1;
			end
		end
	end

	a_addr_hold: assert property (@(posedge clk) disable iff (resetd)
		mem.rd && mem.waitreq |=> mem.rd && $stable(mem.addr));

endmodule

//--- pal_fetch.sv
////////////////////
// Palette loader
// Reads the palette at the framebuffer base in palette mode
// Two entries written per 64-bit word
////////////////////
`timescale 1ns/1ps

module pal_fetch import sys_pkg::*; #(
	parameter int PAL_WORDS = 128
) (
	input  logic       clk,
	input  logic       resetd,
	input  fb_cfg_t    i_fb_cfg,
	mem_rd_if.client   mem,
	output logic       o_pal_wr,
	output logic [7:0] o_pal_a,
	output pal_entry_t o_pal_d
);

	localparam int IW = (PAL_WORDS > 1) ? $clog2(PAL_WORDS) : 1;
	localparam logic [7:0] LAST_A = 8'(2 * PAL_WORDS - 1);

	logic          pal_en;
	logic          pal_en_d;
	logic [31:0]   base_d;
	logic          reload;
	logic          start_load;
	logic          busy;
	logic          rd_r;
	logic          hi_pend;
	logic [IW-1:0] widx;
	mem_addr_t     word_base;
	pal_entry_t    pal_hi;

	assign pal_en     = i_fb_cfg.enable && (i_fb_cfg.format[2:0] == FB_FMT_PAL);
	assign start_load = !busy && reload && pal_en;

	assign mem.rd   = rd_r;
	assign mem.addr = word_base + mem_addr_t'(widx);

	// Track mode entry and base changes
	always_ff @(posedge clk) begin
		if (resetd) begin
			pal_en_d <= 1'b0;
			base_d   <= 32'd0;
		end else begin
			pal_en_d <= pal_en;
			base_d   <= i_fb_cfg.base;
		end
	end

	////////////////////
	// Load control
	////////////////////
	always_ff @(posedge clk) begin
		if (resetd) begin
			reload   <= 1'b0;
			busy     <= 1'b0;
			rd_r     <= 1'b0;
			hi_pend  <= 1'b0;
			widx     <= '0;
			o_pal_wr <= 1'b0;
		end else begin
			o_pal_wr <= 1'b0;
			hi_pend  <= 1'b0;

			if (start_load) begin
				busy   <= 1'b1;
				rd_r   <= 1'b1;
				widx   <= '0;
				reload <= 1'b0;
			end

			// A change mid-load waits for the current load to finish
			if (pal_en && (!pal_en_d || i_fb_cfg.base != base_d))
				reload <= 1'b1;
			else if (!pal_en)
				reload <= 1'b0;

			if (rd_r && !mem.waitreq)
				rd_r <= 1'b0;

			if (mem.rvalid) begin
				o_pal_wr <= 1'b1;
				hi_pend  <= 1'b1;
				if (widx != IW'(PAL_WORDS - 1)) begin
					widx <= widx + 1'b1;
					rd_r <= 1'b1;
				end
			end

			if (hi_pend)
				o_pal_wr <= 1'b1;

			// Done once the high entry of the last word is out
			if (o_pal_wr && o_pal_a == LAST_A)
				busy <= 1'b0;
		end
	end

	// Entry address and data, low entry first
	always_ff @(posedge clk) begin
		if (start_load)
			word_base <= i_fb_cfg.base[31:3];
		if (mem.rvalid) begin
			o_pal_a <= 8'({widx, 1'b0});
			o_pal_d <= mem.rdata[23:0];
			pal_hi  <= mem.rdata[55:32];
		end else if (hi_pend) begin
			o_pal_a <= o_pal_a + 8'd1;
			o_pal_d <= pal_hi;
		end
	end

	a_wr_in_load: assert property (@(posedge clk) disable iff (resetd)
		o_pal_wr |-> busy);

endmodule

//--- audio_mix.sv
////////////////////
// Audio mixer, one channel
// Core plus PCM, crossfeed, attenuation and clamp
////////////////////
`timescale 1ns/1ps

module audio_mix import sys_pkg::*; (
	input  logic       clk,
	input  logic       resetd,
	input  sample_t    i_core,
	input  sample_t    i_pcm,
	input  logic       i_signed,
	input  mix_mode_t  i_mix,
	input  logic [4:0] i_att,
	input  sample_t    i_pre,
	output sample_t    o_pre,
	output sample_t    o_audio
);

	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] sum;
	logic signed [16:0] mixed;
	logic signed [16:0] shifted;

	assign sum = a1 + {i_pcm[15], i_pcm};

	// Crossfeed with the other channel's halved sum
	always_comb begin
		case (i_mix)
			MIX_LOW:  mixed = a2 - (a2 >>> 3) + (i_pre >>> 2);
			MIX_MID:  mixed = a2 - (a2 >>> 2) + (i_pre >>> 1);
			MIX_FULL: mixed = (a2 >>> 1) + i_pre;
			default:  mixed = a2;
		endcase

		if (i_att[4])
			shifted = '0;
		else
			shifted = mixed >>> i_att[3:0];
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1      <= '0;
			a2      <= '0;
			o_pre   <= '0;
			o_audio <= '0;
		end else begin
			// Unsigned core audio is halved into the positive range
			if (i_signed)
				a1 <= {i_core[15], i_core};
			else
				a1 <= {2'b00, i_core[15:1]};

			a2    <= sum;
			o_pre <= sum[16:1];

			// Saturate on 17-bit overflow
			if (shifted[16] != shifted[15])
				o_audio <= {shifted[16], {15{shifted[15]}}};
			else
				o_audio <= shifted[15:0];
		end
	end

endmodule

//--- sys_core.sv
////////////////////
// System core
// Host command port, shared memory read port,
// palette write port and stereo audio mixer
////////////////////
`timescale 1ns/1ps

module sys_core import sys_pkg::*; #(
	parameter int PCM_DEPTH = 16,
	parameter int PAL_WORDS = 128
) (
	input  logic       clk,
	input  logic       resetd,

	// Host command port
	input  logic       i_io_uio,
	input  logic       i_io_strobe,
	input  word_t      i_io_din,

	// Status LEDs
	input  logic [7:0] i_led_core,
	output logic [7:0] o_led,

	// Audio
	input  sample_t    i_core_audio_l,
	input  sample_t    i_core_audio_r,
	input  logic       i_audio_signed,
	input  mix_mode_t  i_audio_mix,
	input  logic       i_sample_ce,
	output sample_t    o_audio_l,
	output sample_t    o_audio_r,

	// Memory read port
	output logic       o_mem_rd,
	output mem_addr_t  o_mem_addr,
	input  logic       i_mem_wait,
	input  mem_data_t  i_mem_rdata,
	input  logic       i_mem_rvalid,

	// Palette write port
	output logic       o_pal_wr,
	output logic [7:0] o_pal_a,
	output pal_entry_t o_pal_d
);

	logic [4:0] vol_att;
	fb_cfg_t    fb_cfg;
	sample_t    pcm_l;
	sample_t    pcm_r;
	sample_t    pre_l;
	sample_t    pre_r;

	mem_rd_if pcm_if ();
	mem_rd_if pal_if ();
	mem_rd_if mem_if ();

	////////////////////
	// Memory port
	////////////////////
	assign o_mem_rd       = mem_if.rd;
	assign o_mem_addr     = mem_if.addr;
	assign mem_if.waitreq = i_mem_wait;
	assign mem_if.rdata   = i_mem_rdata;
	assign mem_if.rvalid  = i_mem_rvalid;

	host_cmd u_host_cmd (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_led_core  (i_led_core),
		.o_led       (o_led),
		.o_vol_att   (vol_att),
		.o_fb_cfg    (fb_cfg)
	);

	mem_arbiter u_mem_arbiter (
		.clk    (clk),
		.resetd (resetd),
		.c0     (pcm_if),
		.c1     (pal_if),
		.m      (mem_if)
	);

	pcm_fetch #(.PCM_DEPTH(PCM_DEPTH)) u_pcm_fetch (
		.clk         (clk),
		.resetd      (resetd),
		.i_sample_ce (i_sample_ce),
		.mem         (pcm_if),
		.o_pcm_l     (pcm_l),
		.o_pcm_r     (pcm_r)
	);

	pal_fetch #(.PAL_WORDS(PAL_WORDS)) u_pal_fetch (
		.clk      (clk),
		.resetd   (resetd),
		.i_fb_cfg (fb_cfg),
		.mem      (pal_if),
		.o_pal_wr (o_pal_wr),
		.o_pal_a  (o_pal_a),
		.o_pal_d  (o_pal_d)
	);

	// Left and right cross-connect their halved sums
	audio_mix u_mix_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_audio_l),
		.i_pcm    (pcm_l),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.i_pre    (pre_r),
		.o_pre    (pre_l),
		.o_audio  (o_audio_l)
	);

	audio_mix u_mix_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_audio_r),
		.i_pcm    (pcm_r),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.i_pre    (pre_l),
		.o_pre    (pre_r),
		.o_audio  (o_audio_r)
	);

endmodule

//--- tb_sys_core.sv
////////////////////
// Testbench for the system core
// Reads commands and expected values from tb_input.txt,
// models the memory port and checks LED, audio,
// PCM fetch and palette load
////////////////////
`timescale 1ns/1ps

module tb_sys_core import sys_pkg::*; ();

	localparam int PCM_DEPTH = 8;
	localparam int PAL_WORDS = 4;

	logic       clk;
	logic       resetd;
	logic       i_io_uio;
	logic       i_io_strobe;
	word_t      i_io_din;
	logic [7:0] i_led_core;
	logic [7:0] o_led;
	sample_t    i_core_audio_l;
	sample_t    i_core_audio_r;
	logic       i_audio_signed;
	mix_mode_t  i_audio_mix;
	logic       i_sample_ce;
	sample_t    o_audio_l;
	sample_t    o_audio_r;
	logic       o_mem_rd;
	mem_addr_t  o_mem_addr;
	logic       i_mem_wait;
	mem_data_t  i_mem_rdata;
	logic       i_mem_rvalid;
	logic       o_pal_wr;
	logic [7:0] o_pal_a;
	pal_entry_t o_pal_d;

	int         value_errs = 0;
	int         other_errs = 0;
	integer     seed = 44;
	int         pcm_idx = 0;
	int         pcm_done = 0;
	int         pal_cnt = 0;
	mem_data_t  last_pcm = '0;
	logic [31:0] fb_base = '0;
	logic [4:0] vol = '0;
	word_t      cmd_words [0:7];
	int         cmd_len;

	// Memory model state
	logic      busy = 1'b0;
	logic      req_pcm;
	mem_addr_t req_addr;
	mem_addr_t pcm_exp_addr;
	int        lat;
	logic      hold_prev = 1'b0;
	mem_addr_t hold_addr;

	sys_core #(.PCM_DEPTH(PCM_DEPTH), .PAL_WORDS(PAL_WORDS)) i_sys_core (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Word contents follow the address
	function automatic mem_data_t mem_word(input mem_addr_t a);
		mem_data_t w;
		w = '0;
		w[15:0] = 16'(a * 3);
		w[31:16] = 16'(-a);
		w[55:32] = 24'(a * 5);
		w[63:56] = 8'(a >> 21);
		return w;
	endfunction

	task automatic report_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		value_errs++;
		$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
	endtask

	task automatic print_counts();
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
	endtask

	task automatic timeout_fail(input string what);
		other_errs++;
		$display("Timeout while waiting for %s", what);
		print_counts();
		$display("Test failed");
		$finish;
	endtask

	////////////////////
	// Memory port model
	////////////////////
	initial begin
		i_mem_wait = 1'b0;
		i_mem_rvalid = 1'b0;
		i_mem_rdata = '0;
		forever begin
			@(negedge clk);
			i_mem_rvalid = 1'b0;
			if (resetd) begin
				busy = 1'b0;
				hold_prev = 1'b0;
			end else begin
				if (busy) begin
					if (lat == 0) begin
						i_mem_rvalid = 1'b1;
						i_mem_rdata = mem_word(req_addr);
						busy = 1'b0;
						if (req_pcm) begin
							pcm_done++;
							last_pcm = mem_word(pcm_exp_addr);
						end
					end else begin
						lat--;
					end
				end
				// Request must hold under wait
				if (hold_prev) begin
					assert (o_mem_rd == 1'b1) else report_value("o_mem_rd", 1, o_mem_rd);
					assert (o_mem_addr == hold_addr)
						else report_value("o_mem_addr", hold_addr, o_mem_addr);
				end
				i_mem_wait = busy ? 1'b1 : (($random(seed) & 3) == 0);
				hold_prev = o_mem_rd && i_mem_wait;
				hold_addr = o_mem_addr;
				if (!busy && o_mem_rd && !i_mem_wait) begin
					busy = 1'b1;
					req_addr = o_mem_addr;
					lat = $random(seed) & 3;
					req_pcm = (o_mem_addr >= PCM_BASE) && (o_mem_addr < PCM_BASE + PCM_DEPTH);
					if (req_pcm) begin
						pcm_exp_addr = PCM_BASE + mem_addr_t'(pcm_idx);
						assert (o_mem_addr == pcm_exp_addr)
							else report_value("o_mem_addr", pcm_exp_addr, o_mem_addr);
						pcm_idx = (pcm_idx + 1) % PCM_DEPTH;
					end
				end
			end
		end
	end

	// Palette write checker
	initial begin
		mem_data_t  w;
		pal_entry_t exp;
		forever begin
			@(negedge clk);
			if (!resetd && o_pal_wr) begin
				w = mem_word(fb_base[31:3] + pal_cnt / 2);
				exp = pal_cnt[0] ? w[55:32] : w[23:0];
				assert (o_pal_a == 8'(pal_cnt)) else report_value("o_pal_a", pal_cnt, o_pal_a);
				assert (o_pal_d == exp) else report_value("o_pal_d", exp, o_pal_d);
				pal_cnt++;
			end
		end
	end

	task automatic send_cmd();
		i_io_uio = 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < cmd_len; i++) begin
			i_io_din = cmd_words[i];
			@(negedge clk);
			i_io_strobe = 1'b1;
			repeat (2) @(negedge clk);
			i_io_strobe = 1'b0;
			repeat (2) @(negedge clk);
			// Track the expected state for later checks
			if (cmd_words[0][7:0] == CMD_FB && i == 2)
				fb_base[15:0] = cmd_words[i];
			if (cmd_words[0][7:0] == CMD_FB && i == 3)
				fb_base[31:16] = cmd_words[i];
			if (cmd_words[0][7:0] == CMD_VOL && i == 1)
				vol = cmd_words[i][4:0];
		end
		i_io_uio = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic run_samples(input int n);
		int target;
		int t;
		for (int i = 0; i < n; i++) begin
			target = pcm_done + 1;
			i_sample_ce = 1'b1;
			@(negedge clk);
			i_sample_ce = 1'b0;
			t = 0;
			// Returns are counted on the falling edge
			while (pcm_done < target) begin
				@(posedge clk);
				t++;
				if (t > 300)
					timeout_fail("a PCM read");
			end
			@(negedge clk);
		end
		repeat (8) @(negedge clk);
		// With neutral mixer settings the output is the PCM word itself
		if (i_core_audio_l == 0 && i_core_audio_r == 0 && i_audio_signed
				&& i_audio_mix == MIX_NONE && vol == 0) begin
			assert (o_audio_l == last_pcm[15:0])
				else report_value("o_audio_l", last_pcm[15:0], o_audio_l);
			assert (o_audio_r == last_pcm[31:16])
				else report_value("o_audio_r", last_pcm[31:16], o_audio_r);
		end
	endtask

	task automatic check_pal(input int n);
		int t;
		t = 0;
		while (pal_cnt < n) begin
			@(posedge clk);
			t++;
			if (t > 3000)
				timeout_fail("palette writes");
		end
		repeat (50) @(posedge clk);
		assert (pal_cnt == n) else report_value("o_pal_wr count", n, pal_cnt);
		pal_cnt = 0;
		@(negedge clk);
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		integer     fd;
		integer     r;
		logic [63:0] op;
		logic [8*200-1:0] line;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		logic [15:0] e;
		logic [15:0] f;
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din = '0;
		i_led_core = 8'ha5;
		i_core_audio_l = '0;
		i_core_audio_r = '0;
		i_audio_signed = 1'b1;
		i_audio_mix = MIX_NONE;
		i_sample_ce = 1'b0;
		repeat (10) @(negedge clk);
		resetd = 1'b0;
		@(negedge clk);
		assert (o_mem_rd == 1'b0) else report_value("o_mem_rd", 0, o_mem_rd);
		assert (o_pal_wr == 1'b0) else report_value("o_pal_wr", 0, o_pal_wr);
		assert (o_led == i_led_core) else report_value("o_led", i_led_core, o_led);

		fd = $fopen("tb_input.txt", "r");
		if (fd == 0)
			other_errs++;
		if (fd == 0)
			$display("Could not open the stimulus file tb_input.txt");
		while (fd != 0 && !$feof(fd)) begin
			op = '0;
			r = $fscanf(fd, "%s", op);
			if (r != 1)
				break;
			if (op == "#") begin
				r = $fgets(line, fd);
			end else if (op == "CMD") begin
				r = $fscanf(fd, "%h", cmd_len);
				for (int i = 0; i < cmd_len; i++)
					r = $fscanf(fd, "%h", cmd_words[i]);
				send_cmd();
			end else if (op == "AUD") begin
				r = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
				i_core_audio_l = a;
				i_core_audio_r = b;
				i_audio_signed = c[0];
				i_audio_mix = mix_mode_t'(d[1:0]);
				repeat (8) @(negedge clk);
				assert (o_audio_l == e) else report_value("o_audio_l", e, o_audio_l);
				assert (o_audio_r == f) else report_value("o_audio_r", f, o_audio_r);
			end else if (op == "SMP") begin
				r = $fscanf(fd, "%h", a);
				run_samples(a);
			end else if (op == "LED") begin
				r = $fscanf(fd, "%h %h", a, b);
				i_led_core = a[7:0];
				repeat (4) @(negedge clk);
				assert (o_led == b[7:0]) else report_value("o_led", b[7:0], o_led);
			end else if (op == "PAL") begin
				r = $fscanf(fd, "%h", a);
				check_pal(a);
			end else if (op == "CON") begin
				// Base change during palette mode races the PCM strobes
				r = $fscanf(fd, "%h %h", a, b);
				cmd_len = 4;
				cmd_words[0] = {8'h00, CMD_FB};
				cmd_words[1] = 16'h8003;
				cmd_words[2] = b;
				cmd_words[3] = 16'h0000;
				fork
					send_cmd();
					run_samples(a);
				join
			end else begin
				other_errs++;
				$display("Unknown opcode in the stimulus file");
			end
		end
		if (fd != 0)
			$fclose(fd);

		print_counts();
		if (value_errs == 0 && other_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb_input.txt
# Hex fields. CMD n words | AUD core_l core_r signed mix exp_l exp_r | SMP strobes
# LED core exp | PAL writes | CON strobes base_lo
# LED overtake and state
LED a5 a5
CMD 2 0025 0f5a
LED a5 aa
LED 00 0a
LED ff fa
# Unknown command is ignored
CMD 2 0030 1234
LED ff fa
# Mixer with PCM still zero
AUD 1234 f000 1 0 1234 f000
AUD 8000 ffff 0 0 4000 7fff
AUD 4000 2000 1 1 3c00 2400
AUD 4000 c000 1 2 2000 e000
AUD 1000 0400 1 3 0a00 0a00
# Shift attenuation and mute
CMD 2 0026 0002
AUD 1234 f000 1 0 048d fc00
CMD 2 0026 0010
AUD 1234 f000 1 0 0000 0000
CMD 2 0026 0000
AUD 0000 0000 1 0 0000 0000
# PCM ring, one full turn
SMP 8
# Clamping with the last PCM word added
AUD 7fff 8000 1 0 7fff 8000
AUD 0000 0000 1 0 0015 fff9
# Palette setup with enable off, then on
CMD 4 002f 0003 0800 0000
PAL 0
CMD 4 002f 8003 0800 0000
PAL 8
# Base change while PCM strobes run
CON a 1000
PAL 8
# Non-palette format
CMD 4 002f 8000 1000 0000
PAL 0

//--- list.f
sys_pkg.sv
mem_rd_if.sv
host_cmd.sv
mem_arbiter.sv
pcm_fetch.sv
pal_fetch.sv
audio_mix.sv
sys_core.sv
tb_sys_core.sv
